//--- Bender.yml
package:
  name: wb_subsystem

sources:
  - wb_pkg.sv
  - wb_result_route.sv
  - wb_branch_resolve.sv
  - wb_stage.sv
  - wbaq.sv
  - arch_state.sv
  - wb_subsystem_top.sv
  - target: test
    files:
      - tb_wb_subsystem.sv

//--- arch_state.sv
module arch_state import wb_pkg::*; (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic [NUM_SLOTS-1:0]                  reg_we,
    input  logic [NUM_SLOTS-1:0][REG_IDX_W-1:0]   reg_addr,
    input  logic [NUM_SLOTS-1:0][GPR_W-1:0]       reg_data,
    input  size_e                                 size,
    input  logic [NUM_SLOTS-1:0]                  seg_we,
    input  logic [NUM_SLOTS-1:0][REG_IDX_W-1:0]   seg_addr,
    input  logic [NUM_SLOTS-1:0][SEG_W-1:0]       seg_data,
    input  logic [REG_IDX_W-1:0]                  rd_reg_addr,
    input  logic [REG_IDX_W-1:0]                  rd_seg_addr,
    output logic [GPR_W-1:0]                      rd_reg_data,
    output logic [SEG_W-1:0]                      rd_seg_data
);

    logic [GPR_W-1:0] gpr  [NUM_REGS];
    logic [SEG_W-1:0] sreg [NUM_REGS];

    function automatic logic [GPR_W-1:0] size_merge(logic [GPR_W-1:0] old_val,
                                                    logic [GPR_W-1:0] new_val,
                                                    size_e            sz);
        case (sz)
            SZ_BYTE: return {old_val[GPR_W-1:8], new_val[7:0]};
            SZ_WORD: return {old_val[GPR_W-1:16], new_val[15:0]};
            default: return new_val; // dword and qword
        endcase
    endfunction

    // ascending port order so the higher slot lands last
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                gpr[r]  <= '0;
                sreg[r] <= '0;
            end
        end else begin
            for (int p = 0; p < NUM_SLOTS; p++) begin
                if (reg_we[p]) begin
                    gpr[reg_addr[p]] <= size_merge(gpr[reg_addr[p]], reg_data[p], size);
                end
                if (seg_we[p]) begin
                    sreg[seg_addr[p]] <= seg_data[p];
                end
            end
        end
    end

    assign rd_reg_data = gpr[rd_reg_addr];
    assign rd_seg_data = sreg[rd_seg_addr];

endmodule

//--- tb_wb_subsystem.sv
module tb_wb_subsystem import wb_pkg::*; ();

    localparam int MAX_CYCLES = 400;

    logic            clk;
    logic            rst_n;
    logic            valid_in;
    wb_bundle_t      bundle;
    br_info_t        br;
    logic            interrupt_in;
    logic            mem_pop;
    logic [2:0]      rd_reg_addr;
    logic [2:0]      rd_seg_addr;
    logic            valid_out;
    logic            stall;
    fetch_redirect_t redirect;
    logic            final_ie_val;
    logic [3:0]      final_ie_type;
    store_t          mem_head;
    logic            mem_valid;
    logic [31:0]     rd_reg_data;
    logic [15:0]     rd_seg_data;

    logic [31:0] exp_gpr [8];
    logic [15:0] exp_seg [8];
    store_t      exp_q [$]; // expected queue contents oldest first
    int          cycle_count = 0;

    wb_subsystem_top UUT (.*);

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Error: run did not finish within %0d cycles", MAX_CYCLES);
            stop_run();
        end
    end

    task automatic stop_run();
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    task automatic check_val(string name, logic [127:0] got, logic [127:0] exp);
        assert (got === exp) else begin
            $display("Fail: time %0t %s got %0h expected %0h", $time, name, got, exp);
            stop_run();
        end
    endtask

    function automatic wb_slot_t make_slot(logic r, logic s, logic m, logic w,
                                           logic [31:0] dest, logic [63:0] data);
        return '{data, dest, r, s, m, w};
    endfunction

    function automatic wb_bundle_t empty_bundle(size_e sz);
        wb_bundle_t b;
        b      = '0;
        b.size = sz;
        return b;
    endfunction

    function automatic logic [63:0] rand64();
        return {$urandom, $urandom};
    endfunction

    function automatic logic [31:0] merge_expected(logic [31:0] old_v, logic [31:0] new_v,
                                                   size_e sz);
        logic [31:0] keep_new; // bits taken from the new value
        case (sz)
            SZ_BYTE: keep_new = 32'h0000_00ff;
            SZ_WORD: keep_new = 32'h0000_ffff;
            default: keep_new = 32'hffff_ffff;
        endcase
        return (old_v & ~keep_new) | (new_v & keep_new);
    endfunction

    task automatic drive(wb_bundle_t b, br_info_t bi, logic irq);
        @(posedge clk);
        bundle       <= b;
        br           <= bi;
        interrupt_in <= irq;
        valid_in     <= 1'b1;
        @(negedge clk);
    endtask

    task automatic retire_idle();
        @(posedge clk);
        valid_in     <= 1'b0;
        bundle       <= empty_bundle(SZ_DWORD);
        br           <= '0;
        interrupt_in <= 1'b0;
        @(negedge clk);
    endtask

    task automatic retire(wb_bundle_t b);
        drive(b, '0, 1'b0);
        retire_idle();
    endtask

    // walks every register so stray writes show up too
    task automatic compare_regs();
        for (int i = 0; i < 8; i++) begin
            @(posedge clk);
            rd_reg_addr <= 3'(i);
            rd_seg_addr <= 3'(i);
            @(negedge clk);
            check_val($sformatf("rd_reg_data[%0d]", i), rd_reg_data, exp_gpr[i]);
            check_val($sformatf("rd_seg_data[%0d]", i), rd_seg_data, exp_seg[i]);
        end
    endtask

    task automatic pop_and_check();
        check_val("mem_valid", mem_valid, 1'b1);
        check_val("mem_head", mem_head, exp_q.pop_front());
        @(posedge clk);
        mem_pop <= 1'b1;
        @(posedge clk);
        mem_pop <= 1'b0;
        @(negedge clk);
    endtask

    task automatic slot_routing();
        wb_bundle_t  b;
        logic [63:0] d [4];
        for (int i = 0; i < 4; i++) begin
            d[i] = rand64();
        end
        b = empty_bundle(SZ_DWORD);
        b.slots[0] = make_slot(1, 0, 0, 1, 32'd2, d[0]);
        b.slots[1] = make_slot(0, 1, 0, 1, 32'd3, d[1]);
        b.slots[2] = make_slot(1, 0, 0, 1, 32'd5, d[2]);
        b.slots[3] = make_slot(0, 1, 0, 1, 32'd6, d[3]);
        retire(b);
        exp_gpr[2] = d[0][31:0];
        exp_seg[3] = d[1][15:0];
        exp_gpr[5] = d[2][31:0];
        exp_seg[6] = d[3][15:0];
        compare_regs();
        b = empty_bundle(SZ_DWORD);
        b.slots[0] = make_slot(1, 0, 0, 0, 32'd4, d[1]); // wb low so no write
        b.slots[1] = make_slot(1, 1, 0, 1, 32'd7, d[2]); // reg beats seg
        b.slots[2] = make_slot(1, 0, 0, 1, 32'd2, d[3]);
        b.slots[3] = make_slot(1, 0, 0, 1, 32'd2, ~d[0]);
        retire(b);
        exp_gpr[7] = d[2][31:0];
        exp_gpr[2] = ~d[0][31:0];
        b = empty_bundle(SZ_DWORD);
        b.slots[0] = make_slot(0, 1, 0, 1, 32'd5, d[1]);
        b.slots[3] = make_slot(0, 1, 0, 1, 32'd5, d[3]);
        retire(b);
        exp_seg[5] = d[3][15:0];
        compare_regs();
    endtask

    task automatic size_merging();
        wb_bundle_t b;
        size_e      sz [3] = '{SZ_BYTE, SZ_WORD, SZ_DWORD};
        b = empty_bundle(SZ_DWORD);
        b.slots[0] = make_slot(1, 0, 0, 1, 32'd0, 64'h11223344);
        retire(b);
        exp_gpr[0] = 32'h11223344;
        for (int i = 0; i < 3; i++) begin
            b = empty_bundle(sz[i]);
            b.slots[2] = make_slot(1, 0, 0, 1, 32'd0, rand64());
            retire(b);
            exp_gpr[0] = merge_expected(exp_gpr[0], b.slots[2].data[31:0], sz[i]);
            compare_regs();
        end
    endtask

    task automatic store_queue_order();
        wb_bundle_t b;
        check_val("mem_valid", mem_valid, 1'b0);
        b = empty_bundle(SZ_WORD);
        b.slots[0] = make_slot(0, 0, 1, 1, $urandom, rand64());
        retire(b);
        exp_q.push_back('{b.slots[0].dest, b.slots[0].data, SZ_WORD});
        b = empty_bundle(SZ_DWORD);
        b.slots[0] = make_slot(0, 0, 1, 0, $urandom, rand64()); // not written back
        b.slots[1] = make_slot(1, 0, 0, 1, 32'd6, rand64());
        b.slots[2] = make_slot(0, 0, 1, 1, $urandom, rand64());
        b.slots[3] = make_slot(0, 0, 1, 1, $urandom, rand64());
        drive(b, '0, 1'b0);
        check_val("stall", stall, 1'b0);
        check_val("valid_out", valid_out, 1'b1);
        retire_idle();
        exp_q.push_back('{b.slots[2].dest, b.slots[2].data, SZ_DWORD});
        exp_gpr[6] = b.slots[1].data[31:0];
        pop_and_check();
        pop_and_check();
        check_val("mem_valid", mem_valid, 1'b0);
        compare_regs();
    endtask

    task automatic back_pressure();
        wb_bundle_t b;
        for (int i = 0; i < QUEUE_DEPTH; i++) begin
            b = empty_bundle(SZ_DWORD);
            b.slots[0] = make_slot(0, 0, 1, 1, $urandom, rand64());
            drive(b, '0, 1'b0);
            check_val("stall", stall, 1'b0);
            exp_q.push_back('{b.slots[0].dest, b.slots[0].data, SZ_DWORD});
        end
        b = empty_bundle(SZ_DWORD);
        b.slots[0] = make_slot(1, 0, 0, 1, 32'd4, rand64()); // no store while the queue is full
        drive(b, '0, 1'b0);
        check_val("stall", stall, 1'b0);
        check_val("valid_out", valid_out, 1'b1);
        exp_gpr[4] = b.slots[0].data[31:0];
        b = empty_bundle(SZ_DWORD);
        b.slots[0] = make_slot(0, 0, 1, 1, $urandom, rand64());
        b.slots[1] = make_slot(1, 0, 0, 1, 32'd3, rand64());
        drive(b, '0, 1'b0);
        check_val("stall", stall, 1'b1);
        check_val("valid_out", valid_out, 1'b0);
        compare_regs(); // reg 3 must stay put while held
        check_val("stall", stall, 1'b1);
        pop_and_check();
        for (int n = 0; n < 8 && stall; n++) begin
            @(negedge clk);
        end
        assert (!stall) else begin
            $display("Error: stall stayed high after the queue head was popped");
            stop_run();
        end
        check_val("valid_out", valid_out, 1'b1);
        retire_idle();
        exp_q.push_back('{b.slots[0].dest, b.slots[0].data, SZ_DWORD});
        exp_gpr[3] = b.slots[1].data[31:0];
        compare_regs();
        while (exp_q.size() > 0) begin
            pop_and_check();
        end
        check_val("mem_valid", mem_valid, 1'b0);
    endtask

    task automatic far_transfer_and_branch();
        wb_bundle_t  b;
        br_info_t    bi;
        logic [15:0] sel;
        logic [31:0] tgt;
        logic [31:0] line;
        logic [31:0] next_line;
        sel = 16'($urandom);
        tgt = $urandom;
        b = empty_bundle(SZ_DWORD);
        b.op = OP_FAR_JMP;
        b.slots[1] = make_slot(0, 0, 0, 1, 32'd0, {16'h0, sel, tgt});
        bi = '{1'b1, 1'b1, 1'b1, $urandom, $urandom};
        drive(b, bi, 1'b0);
        check_val("redirect.new_eip", redirect.new_eip, tgt);
        retire_idle();
        exp_seg[SEG_CS] = sel;
        compare_regs();
        for (int i = 0; i < 16; i++) begin
            b = empty_bundle(SZ_DWORD);
            b.eip = $urandom;
            bi.valid = i[0];
            bi.taken = i[1];
            bi.correct = i[2];
            bi.fip = $urandom;
            bi.fip[4] = i[3];
            bi.fip_p1 = $urandom;
            line = {bi.fip[31:4], 4'h0};
            next_line = {bi.fip_p1[31:4], 4'h0};
            drive(b, bi, 1'b0);
            check_val("redirect.new_fip_e", redirect.new_fip_e, bi.fip[4] ? next_line : line);
            check_val("redirect.new_fip_o", redirect.new_fip_o, bi.fip[4] ? line : next_line);
            check_val("redirect.new_eip", redirect.new_eip, bi.taken ? bi.fip : b.eip);
            check_val("redirect.is_resteer", redirect.is_resteer, bi.valid & ~bi.correct);
        end
        retire_idle();
    endtask

    task automatic exception_merge();
        wb_bundle_t b;
        for (int i = 0; i < 4; i++) begin
            b = empty_bundle(SZ_DWORD);
            b.ie = i[0];
            b.ie_type = ie_type_e'($urandom_range(4, 0));
            drive(b, '0, i[1]);
            check_val("final_ie_val", final_ie_val, b.ie | i[1]);
            check_val("final_ie_type", final_ie_type, {i[1], b.ie_type});
        end
        retire_idle();
    endtask

    initial begin
        void'($urandom(39));
        clk          = 1'b0;
        rst_n        = 1'b0;
        valid_in     = 1'b0;
        bundle       = empty_bundle(SZ_DWORD);
        br           = '0;
        interrupt_in = 1'b0;
        mem_pop      = 1'b0;
        rd_reg_addr  = '0;
        rd_seg_addr  = '0;
        exp_gpr      = '{default: '0};
        exp_seg      = '{default: '0};
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        compare_regs(); // all zero out of reset
        slot_routing();
        size_merging();
        store_queue_order();
        back_pressure();
        far_transfer_and_branch();
        exception_merge();
        $display("TESTS PASSED");
        $finish;
    end

endmodule

//--- wb_branch_resolve.sv
module wb_branch_resolve import wb_pkg::*; (
    input  br_info_t          br,
    input  logic [ADDR_W-1:0] eip,
    input  logic              far_op,
    input  logic [ADDR_W-1:0] far_target,
    output fetch_redirect_t   redirect
);

    logic [ADDR_W-1:0] line;
    logic [ADDR_W-1:0] next_line;
    logic [ADDR_W-1:0] target;

    assign line      = {br.fip[ADDR_W-1:4], 4'h0};
    assign next_line = {br.fip_p1[ADDR_W-1:4], 4'h0};
    assign target    = far_op ? far_target : br.fip;

    always_comb begin
        if (br.fip[4]) begin // odd line first
            redirect.new_fip_e = next_line;
            redirect.new_fip_o = line;
        end else begin
            redirect.new_fip_e = line;
            redirect.new_fip_o = next_line;
        end
        redirect.new_eip    = br.taken ? target : eip;
        redirect.is_resteer = br.valid & ~br.correct;
    end

endmodule

//--- wb_pkg.sv
package wb_pkg;

    localparam int NUM_SLOTS   = 4;
    localparam int QUEUE_DEPTH = 4;
    localparam int PTR_W       = $clog2(QUEUE_DEPTH);
    localparam int CNT_W       = $clog2(QUEUE_DEPTH + 1);

    localparam int DATA_W    = 64;
    localparam int ADDR_W    = 32;
    localparam int GPR_W     = 32;
    localparam int SEG_W     = 16;
    localparam int NUM_REGS  = 8;
    localparam int REG_IDX_W = 3;

    localparam logic [REG_IDX_W-1:0] SEG_CS = 3'd1; // x86 segment index of cs

    typedef enum logic [1:0] {
        OP_NORMAL,
        OP_FAR_JMP,
        OP_FAR_CALL,
        OP_IRET
    } op_kind_e;

    typedef enum logic [1:0] {
        SZ_BYTE,
        SZ_WORD,
        SZ_DWORD,
        SZ_QWORD
    } size_e;

    typedef enum logic [2:0] {
        IE_NONE,
        IE_DIV,
        IE_PAGE,
        IE_GP,
        IE_UD
    } ie_type_e;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [ADDR_W-1:0] dest;   // reg index in [2:0] or mem address
        logic              is_reg;
        logic              is_seg;
        logic              is_mem;
        logic              wb;
    } wb_slot_t;

    typedef struct packed {
        wb_slot_t [NUM_SLOTS-1:0] slots;
        size_e                    size;
        op_kind_e                 op;
        logic [ADDR_W-1:0]        eip;     // fall-through
        logic [SEG_W-1:0]         cs;
        logic                     ie;
        ie_type_e                 ie_type;
    } wb_bundle_t;

    typedef struct packed {
        logic              valid;
        logic              taken;
        logic              correct;
        logic [ADDR_W-1:0] fip;
        logic [ADDR_W-1:0] fip_p1;
    } br_info_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
        size_e             size;
    } store_t;

    typedef struct packed {
        logic [ADDR_W-1:0] new_fip_e;
        logic [ADDR_W-1:0] new_fip_o;
        logic [ADDR_W-1:0] new_eip;
        logic              is_resteer;
    } fetch_redirect_t;

    // far jmp, far call and iret all load cs:eip together
    function automatic logic is_far_op(op_kind_e op);
        return op != OP_NORMAL;
    endfunction

endpackage

//--- wb_result_route.sv
module wb_result_route import wb_pkg::*; (
    input  logic                                  valid_out,
    input  wb_bundle_t                            bundle,
    output logic [NUM_SLOTS-1:0]                  reg_we,
    output logic [NUM_SLOTS-1:0]                  seg_we,
    output logic [NUM_SLOTS-1:0][REG_IDX_W-1:0]   reg_addr,
    output logic [NUM_SLOTS-1:0][REG_IDX_W-1:0]   seg_addr,
    output logic [NUM_SLOTS-1:0][GPR_W-1:0]       reg_data,
    output logic [NUM_SLOTS-1:0][SEG_W-1:0]       seg_data,
    output store_t                                store,
    output logic                                  store_req
);

    logic                 far_op;
    logic [NUM_SLOTS-1:0] cls_reg;
    logic [NUM_SLOTS-1:0] cls_seg;
    logic [NUM_SLOTS-1:0] cls_mem;

    assign far_op = is_far_op(bundle.op);

    // class decode with reg over seg over mem
    always_comb begin
        wb_slot_t slot;
        logic     cs_slot;
        for (int i = 0; i < NUM_SLOTS; i++) begin
            slot    = bundle.slots[i];
            cs_slot = far_op && (i == 1);
            cls_reg[i] = slot.is_reg & ~cs_slot;
            cls_seg[i] = (~slot.is_reg & slot.is_seg) | cs_slot;
            cls_mem[i] = ~slot.is_reg & ~slot.is_seg & slot.is_mem & slot.wb & ~cs_slot;

            reg_we[i]   = valid_out & slot.wb & cls_reg[i];
            seg_we[i]   = valid_out & slot.wb & cls_seg[i];
            reg_addr[i] = slot.dest[REG_IDX_W-1:0];
            reg_data[i] = slot.data[GPR_W-1:0];
            if (cs_slot) begin
                seg_addr[i] = SEG_CS;
                seg_data[i] = slot.data[47:32]; // selector half of far pointer
            end else begin
                seg_addr[i] = slot.dest[REG_IDX_W-1:0];
                seg_data[i] = slot.data[SEG_W-1:0];
            end
        end
    end

    // lowest store slot wins
    always_comb begin
        store.addr = bundle.slots[0].dest;
        store.data = bundle.slots[0].data;
        for (int i = NUM_SLOTS - 1; i >= 0; i--) begin
            if (cls_mem[i]) begin
                store.addr = bundle.slots[i].dest;
                store.data = bundle.slots[i].data;
            end
        end
        store.size = far_op ? SZ_QWORD : bundle.size;
    end

    assign store_req = |cls_mem; // independent of valid_out

endmodule

//--- wb_stage.sv
module wb_stage import wb_pkg::*; (
    input  logic                                  valid_in,
    input  wb_bundle_t                            bundle,
    input  br_info_t                              br,
    input  logic                                  interrupt_in,
    input  logic                                  wbaq_full,
    output logic                                  valid_out,
    output logic                                  stall,
    output logic                                  push,
    output logic [NUM_SLOTS-1:0]                  reg_we,
    output logic [NUM_SLOTS-1:0]                  seg_we,
    output logic [NUM_SLOTS-1:0][REG_IDX_W-1:0]   reg_addr,
    output logic [NUM_SLOTS-1:0][REG_IDX_W-1:0]   seg_addr,
    output logic [NUM_SLOTS-1:0][GPR_W-1:0]       reg_data,
    output logic [NUM_SLOTS-1:0][SEG_W-1:0]       seg_data,
    output size_e                                 size,
    output store_t                                store,
    output fetch_redirect_t                       redirect,
    output logic                                  final_ie_val,
    output logic [3:0]                            final_ie_type
);

    logic store_req;
    logic far_op;

    assign far_op = is_far_op(bundle.op);
    assign size   = bundle.size;

    wb_result_route u_route (
        .valid_out (valid_out),
        .bundle    (bundle),
        .reg_we    (reg_we),
        .seg_we    (seg_we),
        .reg_addr  (reg_addr),
        .seg_addr  (seg_addr),
        .reg_data  (reg_data),
        .seg_data  (seg_data),
        .store     (store),
        .store_req (store_req)
    );

    wb_branch_resolve u_branch (
        .br         (br),
        .eip        (bundle.eip),
        .far_op     (far_op),
        .far_target (bundle.slots[1].data[ADDR_W-1:0]), // new eip of far pointer
        .redirect   (redirect)
    );

    // hold the instruction while the store queue is full
    assign stall     = store_req & wbaq_full;
    assign valid_out = valid_in & ~stall;
    assign push      = store_req & valid_out;

    assign final_ie_val  = bundle.ie | interrupt_in;
    assign final_ie_type = {interrupt_in, bundle.ie_type}; // irq flag on top

endmodule

//--- wb_subsystem.f
wb_pkg.sv
wb_result_route.sv
wb_branch_resolve.sv
wb_stage.sv
wbaq.sv
arch_state.sv
wb_subsystem_top.sv
tb_wb_subsystem.sv

//--- wb_subsystem_top.sv
module wb_subsystem_top import wb_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  valid_in,
    input  wb_bundle_t            bundle,
    input  br_info_t              br,
    input  logic                  interrupt_in,
    input  logic                  mem_pop,
    input  logic [REG_IDX_W-1:0]  rd_reg_addr,
    input  logic [REG_IDX_W-1:0]  rd_seg_addr,
    output logic                  valid_out,
    output logic                  stall,
    output fetch_redirect_t       redirect,
    output logic                  final_ie_val,
    output logic [3:0]            final_ie_type,
    output store_t                mem_head,
    output logic                  mem_valid,
    output logic [GPR_W-1:0]      rd_reg_data,
    output logic [SEG_W-1:0]      rd_seg_data
);

    logic                                push;
    logic                                wbaq_full;
    store_t                              store;
    size_e                               size;
    logic [NUM_SLOTS-1:0]                reg_we;
    logic [NUM_SLOTS-1:0]                seg_we;
    logic [NUM_SLOTS-1:0][REG_IDX_W-1:0] reg_addr;
    logic [NUM_SLOTS-1:0][REG_IDX_W-1:0] seg_addr;
    logic [NUM_SLOTS-1:0][GPR_W-1:0]     reg_data;
    logic [NUM_SLOTS-1:0][SEG_W-1:0]     seg_data;

    wb_stage u_stage (
        .valid_in      (valid_in),
        .bundle        (bundle),
        .br            (br),
        .interrupt_in  (interrupt_in),
        .wbaq_full     (wbaq_full),
        .valid_out     (valid_out),
        .stall         (stall),
        .push          (push),
        .reg_we        (reg_we),
        .seg_we        (seg_we),
        .reg_addr      (reg_addr),
        .seg_addr      (seg_addr),
        .reg_data      (reg_data),
        .seg_data      (seg_data),
        .size          (size),
        .store         (store),
        .redirect      (redirect),
        .final_ie_val  (final_ie_val),
        .final_ie_type (final_ie_type)
    );

    wbaq u_wbaq (
        .clk        (clk),
        .rst_n      (rst_n),
        .push       (push),
        .push_store (store),
        .pop        (mem_pop),
        .head       (mem_head),
        .mem_valid  (mem_valid),
        .full       (wbaq_full)
    );

    arch_state u_state (
        .clk         (clk),
        .rst_n       (rst_n),
        .reg_we      (reg_we),
        .reg_addr    (reg_addr),
        .reg_data    (reg_data),
        .size        (size),
        .seg_we      (seg_we),
        .seg_addr    (seg_addr),
        .seg_data    (seg_data),
        .rd_reg_addr (rd_reg_addr),
        .rd_seg_addr (rd_seg_addr),
        .rd_reg_data (rd_reg_data),
        .rd_seg_data (rd_seg_data)
    );

endmodule

//--- wbaq.sv
module wbaq import wb_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   push,
    input  store_t push_store,
    input  logic   pop,
    output store_t head,
    output logic   mem_valid,
    output logic   full
);

    store_t           entries [QUEUE_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    function automatic logic [PTR_W-1:0] ptr_inc(logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(QUEUE_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full      = (count == CNT_W'(QUEUE_DEPTH));
    assign mem_valid = (count != '0);
    assign head      = entries[rd_ptr];

    assign do_push = push & ~full;
    assign do_pop  = pop & mem_valid; // pop on empty dropped

    always_ff @(posedge clk) begin
        if (do_push) begin
            entries[wr_ptr] <= push_store;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule
